/* Bender.yml */
package:
  name: sdram_controller

sources:
  # rtl in compile order
  - source/sdramPkg.sv
  - source/sdramCmdIf.sv
  - source/dramSequencer.sv
  - source/refreshScheduler.sv
  - source/commandRegister.sv
  - source/sdramController.sv
  # testbench and bound assertions
  - target: test
    files:
      - test/sdramController_assertions.sv
      - test/sdramControllerTb.sv

/* flist.f */
source/sdramPkg.sv
source/sdramCmdIf.sv
source/dramSequencer.sv
source/refreshScheduler.sv
source/commandRegister.sv
source/sdramController.sv
test/sdramController_assertions.sv
test/sdramControllerTb.sv

/* source/commandRegister.sv */
/*
 * sdram pin register
 *   opcode to cke/cs/ras/cas/we levels
 *   registered pins, address, bank and cpu reset release
 */

`timescale 1ns/1ps

module commandRegister (
	input logic Clock,
	input logic Reset_L,
	sdramCmdIf.register cmd,
	output logic sdramCke,					// active high
	output logic sdramCs,					// active low
	output logic sdramRas,					// active low
	output logic sdramCas,					// active low
	output logic sdramWe,					// active low
	output sdramPkg::rowAddrT sdramAddr,
	output sdramPkg::bankT sdramBa,
	output logic cpuResetOut				// low holds the cpu in reset
);

	logic [4:0] pinCode;					// {cke, cs, ras, cas, we}

	always_comb
	begin
		case (cmd.op)
			sdramPkg::PowerUp:		pinCode = 5'b00000;
			sdramPkg::Nop:			pinCode = 5'b10111;
			sdramPkg::PrechargeAll:	pinCode = 5'b10010;
			sdramPkg::AutoRefresh:	pinCode = 5'b10001;
			sdramPkg::ModeSet:		pinCode = 5'b10000;
			default:				pinCode = 5'b10111;		// nop
		endcase
	end

	// pins change one cycle after the sequencer state
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			{sdramCke, sdramCs, sdramRas, sdramCas, sdramWe} <= 5'b00000;	// power-up levels
			sdramAddr <= '0;
			sdramBa <= '0;
			cpuResetOut <= 1'b0;
		end
		else
		begin
			{sdramCke, sdramCs, sdramRas, sdramCas, sdramWe} <= pinCode;
			sdramAddr <= cmd.addr;
			sdramBa <= cmd.ba;
			cpuResetOut <= cmd.initDone;	// cpu runs once init is done
		end
	end

endmodule

/* source/dramSequencer.sv */
/*
 * sdram sequencer FSM
 *   power-up wait, precharge-all, initial auto-refreshes, mode set
 *   idle with periodic refresh on request from the scheduler
 *   ack side of the four-phase refresh handshake
 */

`timescale 1ns/1ps

module dramSequencer (
	input logic Clock,
	input logic Reset_L,						// async, active low
	input logic refreshReq,						// from refresh scheduler
	output logic refreshAck,					// held for the whole refresh sequence
	sdramCmdIf.seq cmd
);

	sdramPkg::seqStateT state;
	sdramPkg::delayT delay;						// shared down-counter for power-up and gaps
	sdramPkg::refCountT refCount;				// initial refreshes issued so far

	////////////////////
	// state register and counters

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= sdramPkg::PowerWait;
			delay <= sdramPkg::delayT'(sdramPkg::PowerUpCycles - 1);	// armed for power-up
			refCount <= '0;
			refreshAck <= 1'b0;
		end
		else
		begin
			case (state)
				sdramPkg::PowerWait:
					if (delay == '0)
						state <= sdramPkg::FirstNop;
					else
						delay <= delay - 1'b1;

				sdramPkg::FirstNop:
					state <= sdramPkg::InitPrecharge;

				sdramPkg::InitPrecharge:
					state <= sdramPkg::PrechargeNop;

				sdramPkg::PrechargeNop:
					state <= sdramPkg::InitRefresh;

				sdramPkg::InitRefresh:
				begin
					refCount <= refCount + 1'b1;
					delay <= sdramPkg::delayT'(sdramPkg::RefreshGapCycles - 1);
					state <= sdramPkg::InitRefreshGap;
				end

				sdramPkg::InitRefreshGap:
					if (delay != '0)
						delay <= delay - 1'b1;
					else if (refCount == sdramPkg::refCountT'(sdramPkg::InitRefreshCount))
						state <= sdramPkg::LoadMode;		// all init refreshes done
					else
						state <= sdramPkg::InitRefresh;

				sdramPkg::LoadMode:
				begin
					delay <= sdramPkg::delayT'(sdramPkg::ModeGapCycles - 1);
					state <= sdramPkg::ModeGap;
				end

				sdramPkg::ModeGap:
					if (delay == '0)
						state <= sdramPkg::Idle;
					else
						delay <= delay - 1'b1;

				// handshake: ack rises as idle is left, falls once req is gone
				sdramPkg::Idle:
					if (refreshAck)
					begin
						if (!refreshReq)
							refreshAck <= 1'b0;
					end
					else if (refreshReq)
					begin
						refreshAck <= 1'b1;
						state <= sdramPkg::RefPrecharge;
					end

				sdramPkg::RefPrecharge:
					state <= sdramPkg::RefNop;

				sdramPkg::RefNop:
					state <= sdramPkg::RefRefresh;

				sdramPkg::RefRefresh:
				begin
					delay <= sdramPkg::delayT'(sdramPkg::RefreshGapCycles - 1);
					state <= sdramPkg::RefGap;
				end

				sdramPkg::RefGap:
					if (delay != '0)
						delay <= delay - 1'b1;
					else
					begin
						state <= sdramPkg::Idle;
						if (!refreshReq)
							refreshAck <= 1'b0;			// scheduler reloads on this fall
					end

				default:
					state <= sdramPkg::PowerWait;		// unused encodings restart init
			endcase
		end
	end

	////////////////////
	// command per state

	always_comb
	begin
		cmd.op = sdramPkg::Nop;					// gaps, first nop and idle
		cmd.addr = '0;
		cmd.ba = '0;
		case (state)
			sdramPkg::PowerWait:
				cmd.op = sdramPkg::PowerUp;
			sdramPkg::InitPrecharge, sdramPkg::RefPrecharge:
			begin
				cmd.op = sdramPkg::PrechargeAll;
				cmd.addr[10] = 1'b1;			// all banks
			end
			sdramPkg::InitRefresh, sdramPkg::RefRefresh:
				cmd.op = sdramPkg::AutoRefresh;
			sdramPkg::LoadMode:
			begin
				cmd.op = sdramPkg::ModeSet;
				cmd.addr = sdramPkg::ModeValue;	// ba stays 0
			end
			default:
				cmd.op = sdramPkg::Nop;
		endcase
	end

	// init is over once idle is reached, refreshes keep it high
	assign cmd.initDone = state inside {sdramPkg::Idle, sdramPkg::RefPrecharge,
		sdramPkg::RefNop, sdramPkg::RefRefresh, sdramPkg::RefGap};

endmodule

/* source/refreshScheduler.sv */
/*
 * refresh interval timer
 *   counts RefreshInterval cycles, then raises refreshReq
 *   req side of the four-phase handshake with the sequencer
 */

`timescale 1ns/1ps

module refreshScheduler (
	input logic Clock,
	input logic Reset_L,
	input logic refreshAck,					// from sequencer
	output logic refreshReq
);

	sdramPkg::delayT count;					// cycles left until next request
	logic ackQ;								// ack one cycle back
	logic ackFall;

	assign ackFall = ackQ && !refreshAck;	// refresh sequence finished

	////////////////////
	// interval counter

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			count <= sdramPkg::delayT'(sdramPkg::RefreshInterval - 1);
			ackQ <= 1'b0;
		end
		else
		begin
			ackQ <= refreshAck;
			if (ackFall)
				count <= sdramPkg::delayT'(sdramPkg::RefreshInterval - 1);	// restart
			else if (count != '0)
				count <= count - 1'b1;		// holds at zero until acked
		end
	end

	////////////////////
	// request

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
			refreshReq <= 1'b0;
		else if (refreshAck || ackFall)
			refreshReq <= 1'b0;				// drop once seen, stay low while reloading
		else if (count == '0)
			refreshReq <= 1'b1;
	end

endmodule

/* source/sdramCmdIf.sv */
/*
 * one sdram command from the sequencer to the command register
 *   op, addr, ba   - command and its address fields
 *   initDone       - init sequence finished, releases the cpu reset
 */

`timescale 1ns/1ps

interface sdramCmdIf;

	sdramPkg::sdramOpT op;				// command for this cycle
	sdramPkg::rowAddrT addr;			// A10 set for precharge-all, mode word for mode set
	sdramPkg::bankT ba;					// zero for every command used here
	logic initDone;						// high from idle onward

	// sequencer side
	modport seq (
		output op,
		output addr,
		output ba,
		output initDone
	);

	// command register side
	modport register (
		input op,
		input addr,
		input ba,
		input initDone
	);

endinterface

/* source/sdramController.sv */
/*
 * sdram init and refresh controller, top level
 *   dramSequencer    - init and refresh FSM
 *   refreshScheduler - refresh interval and request
 *   commandRegister  - registered sdram pins and cpu reset
 */

`timescale 1ns/1ps

module sdramController (
	input logic Clock,						// 50 MHz
	input logic Reset_L,
	output logic sdramCke,
	output logic sdramCs,
	output logic sdramRas,
	output logic sdramCas,
	output logic sdramWe,
	output sdramPkg::rowAddrT sdramAddr,
	output sdramPkg::bankT sdramBa,
	output logic cpuResetOut
);

	logic refreshReq;						// scheduler to sequencer
	logic refreshAck;						// sequencer to scheduler

	sdramCmdIf cmdIf ();					// sequencer to pin register

	dramSequencer dramSequencer_i (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.refreshReq (refreshReq),
		.refreshAck (refreshAck),
		.cmd        (cmdIf.seq)
	);

	refreshScheduler refreshScheduler_i (
		.Clock      (Clock),
		.Reset_L    (Reset_L),
		.refreshAck (refreshAck),
		.refreshReq (refreshReq)
	);

	commandRegister commandRegister_i (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.cmd         (cmdIf.register),
		.sdramCke    (sdramCke),
		.sdramCs     (sdramCs),
		.sdramRas    (sdramRas),
		.sdramCas    (sdramCas),
		.sdramWe     (sdramWe),
		.sdramAddr   (sdramAddr),
		.sdramBa     (sdramBa),
		.cpuResetOut (cpuResetOut)
	);

endmodule

/* source/sdramPkg.sv */
/*
 * shared definitions for the sdram init and refresh controller
 *   sdramOpT   - commands put on the sdram pins
 *   seqStateT  - sequencer states
 *   rowAddrT, bankT, delayT, refCountT - address and counter types
 *   timing constants for a 50 MHz clock and the mode register word
 */

package sdramPkg;

	////////////////////
	// sizes and timing

	localparam int unsigned DelayWidth = 13;			// wide enough for the power-up wait
	localparam int unsigned PowerUpCycles = 5000;		// 100 us at 50 MHz
	localparam int unsigned InitRefreshCount = 8;		// auto-refreshes before mode set
	localparam int unsigned RefreshGapCycles = 3;		// nops after each auto-refresh
	localparam int unsigned ModeGapCycles = 3;			// nops after mode set
	localparam int unsigned RefreshInterval = 375;		// ~7.5 us between refresh requests
	localparam int unsigned RefCountWidth = $clog2(InitRefreshCount + 1);

	////////////////////
	// types

	typedef logic [12:0] rowAddrT;						// A12..A0
	typedef logic [1:0] bankT;							// BA1..BA0
	typedef logic [DelayWidth-1:0] delayT;
	typedef logic [RefCountWidth-1:0] refCountT;

	typedef enum logic [2:0] {
		PowerUp,										// cke and cs low
		Nop,
		PrechargeAll,									// needs A10 high
		AutoRefresh,
		ModeSet
	} sdramOpT;

	typedef enum logic [3:0] {
		PowerWait,
		FirstNop,
		InitPrecharge,
		PrechargeNop,
		InitRefresh,
		InitRefreshGap,
		LoadMode,
		ModeGap,
		Idle,
		RefPrecharge,
		RefNop,
		RefRefresh,
		RefGap
	} seqStateT;

	// mode word: burst length 1, sequential, CAS latency 2 in bits 6..4
	localparam rowAddrT ModeValue = 13'h0020;

endpackage

/* test/sdramControllerTb.sv */
/*
 * testbench for the sdram init and refresh controller
 *   20 ns clock, power-on reset, random mid-run resets from an LFSR
 *   model of the expected command stream, decoded from the pins
 *   compare tasks per result type, cycle timeout
 */

`timescale 1ns/1ps

module sdramControllerTb;

	localparam int PowerCycles = sdramPkg::PowerUpCycles;
	localparam int RefreshGap = sdramPkg::RefreshGapCycles;
	localparam int Interval = sdramPkg::RefreshInterval;
	localparam int RefreshStart = PowerCycles + 4;			// first init auto-refresh
	localparam int ModeAt = RefreshStart + sdramPkg::InitRefreshCount * (RefreshGap + 1);
	localparam int IdleStart = ModeAt + sdramPkg::ModeGapCycles + 1;	// cpu reset goes high
	localparam int Slack = 10;								// handshake cycles per refresh
	localparam int LatestSecondEnd = IdleStart + 3 + Interval + Slack + RefreshGap;
	localparam int ResetSpan = LatestSecondEnd - 100 + 1;	// reset points 100..second refresh end
	localparam int SpanBits = $clog2(ResetSpan);
	localparam int MidResets = 3;
	localparam int FinalRefreshes = 4;						// three spacings in the last run
	localparam int TimeoutCycles = 4 * (MidResets + 1) * (IdleStart + 3 * Interval);
	// burst length 1, sequential, CAS latency 2, write burst mode 0
	localparam sdramPkg::rowAddrT ExpectedMode = {3'b000, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};
	localparam sdramPkg::rowAddrT AllBanks = 13'h0400;		// A10

	logic Clock = 1'b0;
	logic Reset_L;
	logic sdramCke;
	logic sdramCs;
	logic sdramRas;
	logic sdramCas;
	logic sdramWe;
	sdramPkg::rowAddrT sdramAddr;
	sdramPkg::bankT sdramBa;
	logic cpuResetOut;

	logic [31:0] lfsr = 32'hf269_9d5a;
	int cycleCount = 0;
	int refPhase;							// 0 idle, else position in refresh sequence
	int lastRefresh;						// cycle of last auto-refresh in idle
	int periodicCount;
	int resetPoint [MidResets];
	int resetLen [MidResets];
	int run;
	int value;

	always #10 Clock = ~Clock;

	sdramController sdramController_i (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.sdramCke    (sdramCke),
		.sdramCs     (sdramCs),
		.sdramRas    (sdramRas),
		.sdramCas    (sdramCas),
		.sdramWe     (sdramWe),
		.sdramAddr   (sdramAddr),
		.sdramBa     (sdramBa),
		.cpuResetOut (cpuResetOut)
	);

	////////////////////
	// error stop and compare tasks

	task automatic stopOnError(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkOp(input string name, input sdramPkg::sdramOpT expected,
		input sdramPkg::sdramOpT actual);
		if (actual !== expected)
			stopOnError($sformatf("FAIL %s: expected %s actual %s", name, expected.name(),
				actual.name()));
	endtask

	task automatic checkAddr(input string name, input sdramPkg::rowAddrT expected,
		input sdramPkg::rowAddrT actual);
		if (actual !== expected)
			stopOnError($sformatf("FAIL %s: expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkBank(input string name, input sdramPkg::bankT expected,
		input sdramPkg::bankT actual);
		if (actual !== expected)
			stopOnError($sformatf("FAIL %s: expected %0d actual %0d", name, expected, actual));
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stopOnError($sformatf("FAIL %s: expected %b actual %b", name, expected, actual));
	endtask

	////////////////////
	// random numbers

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic randomBits(input int count, output int bits);
		bits = 0;
		repeat (count)
		begin
			lfsr = lfsrNext(lfsr);
			bits = (bits << 1) | lfsr[0];	// one step per bit
		end
	endtask

	////////////////////
	// reference model

	// {cke, cs, ras, cas, we} per the sdram command truth table
	function automatic sdramPkg::sdramOpT decodePins(input logic [4:0] pins, output bit known);
		known = 1'b1;
		case (pins)
			5'b00000: return sdramPkg::PowerUp;
			5'b10111: return sdramPkg::Nop;
			5'b10010: return sdramPkg::PrechargeAll;
			5'b10001: return sdramPkg::AutoRefresh;
			5'b10000: return sdramPkg::ModeSet;
			default: known = 1'b0;
		endcase
		return sdramPkg::Nop;
	endfunction

	// expected command n cycles after reset release, up to idle
	function automatic sdramPkg::sdramOpT initOp(input int n);
		if (n <= PowerCycles)
			return sdramPkg::PowerUp;
		if (n == PowerCycles + 2)
			return sdramPkg::PrechargeAll;
		if (n < RefreshStart)
			return sdramPkg::Nop;				// first nop and nop after precharge
		if (n < ModeAt)
			return ((n - RefreshStart) % (RefreshGap + 1) == 0) ? sdramPkg::AutoRefresh
				: sdramPkg::Nop;
		return (n == ModeAt) ? sdramPkg::ModeSet : sdramPkg::Nop;
	endfunction

	function automatic sdramPkg::rowAddrT addrFor(input sdramPkg::sdramOpT op);
		case (op)
			sdramPkg::PrechargeAll: return AllBanks;
			sdramPkg::ModeSet: return ExpectedMode;
			default: return '0;
		endcase
	endfunction

	task automatic readPins(input int n, output sdramPkg::sdramOpT op);
		bit known;
		op = decodePins({sdramCke, sdramCs, sdramRas, sdramCas, sdramWe}, known);
		if (!known)
			stopOnError($sformatf("pin levels %b at cycle %0d are no valid sdram command",
				{sdramCke, sdramCs, sdramRas, sdramCas, sdramWe}, n));
	endtask

	task automatic checkReset(input string where);
		sdramPkg::sdramOpT op;
		readPins(0, op);
		checkOp({where, " command"}, sdramPkg::PowerUp, op);
		checkAddr({where, " address"}, '0, sdramAddr);
		checkBank({where, " bank"}, '0, sdramBa);
		checkBit({where, " cpu reset"}, 1'b0, cpuResetOut);
		checkBit({where, " refresh request"}, 1'b0, sdramController_i.refreshReq);
		checkBit({where, " refresh ack"}, 1'b0, sdramController_i.refreshAck);
	endtask

	task automatic checkCycle(input int n);
		sdramPkg::sdramOpT op;
		readPins(n, op);
		checkBank($sformatf("bank at cycle %0d", n), '0, sdramBa);
		checkBit($sformatf("cpu reset at cycle %0d", n), n >= IdleStart, cpuResetOut);
		if (n < IdleStart)
			checkOp($sformatf("init command at cycle %0d", n), initOp(n), op);
		else if (refPhase == 0)
		begin
			if (op == sdramPkg::PrechargeAll)
				refPhase = 1;					// refresh sequence starts
			else
			begin
				checkOp($sformatf("idle command at cycle %0d", n), sdramPkg::Nop, op);
				if (n - lastRefresh > Interval + Slack)
					stopOnError($sformatf("no refresh within %0d cycles at cycle %0d",
						Interval + Slack, n));
			end
		end
		else
		begin
			checkOp($sformatf("refresh step %0d at cycle %0d", refPhase, n),
				(refPhase == 2) ? sdramPkg::AutoRefresh : sdramPkg::Nop, op);
			if (refPhase == 2)
			begin
				if (periodicCount > 0 && (n - lastRefresh < Interval
					|| n - lastRefresh > Interval + Slack))
					stopOnError($sformatf("FAIL refresh spacing: expected %0d to %0d actual %0d",
						Interval, Interval + Slack, n - lastRefresh));
				lastRefresh = n;
				periodicCount++;
			end
			refPhase = (refPhase == RefreshGap + 2) ? 0 : refPhase + 1;
		end
		checkAddr($sformatf("address at cycle %0d", n), addrFor(op), sdramAddr);
	endtask

	////////////////////
	// run control

	task automatic holdReset(input int len);
		Reset_L = 1'b0;
		repeat (len)
		begin
			@(negedge Clock);
			checkReset("in reset");
		end
		Reset_L = 1'b1;						// released on a falling edge
	endtask

	// one run from reset release, ends at a cycle or after some idle refreshes
	task automatic runStream(input int stopCycle, input int refreshGoal);
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		refPhase = 0;
		periodicCount = 0;
		lastRefresh = IdleStart;
		while (!done)
		begin
			@(negedge Clock);
			n++;
			checkCycle(n);
			if (sdramController_i.commandRegister_i.pinRules_i.failCount != 0)
				stopOnError($sformatf("a pin assertion failed by cycle %0d", n));
			done = (stopCycle > 0 && n >= stopCycle) || (refreshGoal > 0
				&& periodicCount >= refreshGoal);
		end
	endtask

	always @(posedge Clock)
	begin
		cycleCount++;
		if (cycleCount > TimeoutCycles)
			stopOnError($sformatf("timeout, run took more than %0d cycles", TimeoutCycles));
	end

	initial
	begin
		Reset_L = 1'b0;
		for (run = 0; run < MidResets; run++)
		begin
			do
				randomBits(SpanBits, value);	// redraw until inside the span
			while (value >= ResetSpan);
			resetPoint[run] = 100 + value;
			randomBits(2, value);
			resetLen[run] = value + 1;
		end
		holdReset(4);
		for (run = 0; run < MidResets; run++)
		begin
			runStream(resetPoint[run], 0);
			$display("reset at cycle %0d for %0d cycles", resetPoint[run], resetLen[run]);
			Reset_L = 1'b0;
			#1;
			checkReset("reset entry");		// async, pins drop at once
			holdReset(resetLen[run]);
		end
		runStream(0, FinalRefreshes);
		if (sdramController_i.commandRegister_i.pinRules_i.failCount == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
			stopOnError("a pin assertion failed");
	end

endmodule

/* test/sdramController_assertions.sv */
/*
 * pin-level command rules, bound into commandRegister
 *   auto-refresh follows a nop, precharge-all has A10 high
 *   cpu reset only falls while Reset_L is low
 */

`timescale 1ns/1ps

module sdramController_assertions (
	input logic Clock,
	input logic Reset_L,
	input logic [4:0] pins,					// {cke, cs, ras, cas, we}
	input sdramPkg::rowAddrT sdramAddr,
	input logic cpuResetOut
);

	localparam logic [4:0] NopPins = 5'b10111;
	localparam logic [4:0] PrechargePins = 5'b10010;
	localparam logic [4:0] RefreshPins = 5'b10001;

	int unsigned failCount = 0;				// failed assertions so far

	refreshAfterNop: assert property (@(posedge Clock) disable iff (!Reset_L)
		pins == RefreshPins |-> $past(pins) == NopPins)
	else
	begin
		$error("auto-refresh without a nop before it");
		failCount++;
	end

	prechargeA10: assert property (@(posedge Clock) disable iff (!Reset_L)
		pins == PrechargePins |-> sdramAddr[10])
	else
	begin
		$error("precharge-all with A10 low");
		failCount++;
	end

	// only a reset may take the cpu back into reset
	cpuResetHolds: assert property (@(posedge Clock) $fell(cpuResetOut) |-> !Reset_L)
	else
	begin
		$error("cpu reset fell while Reset_L was high");
		failCount++;
	end

endmodule

bind commandRegister sdramController_assertions pinRules_i (
	.Clock       (Clock),
	.Reset_L     (Reset_L),
	.pins        ({sdramCke, sdramCs, sdramRas, sdramCas, sdramWe}),
	.sdramAddr   (sdramAddr),
	.cpuResetOut (cpuResetOut)
);
